// ==== Bender.yml ====
package:
  name: cpu_controller

sources:
  # Design
  - hdl/cpuCtrlPkg.sv
  - hdl/instrDecoder.sv
  - hdl/branchUnit.sv
  - hdl/controlSequencer.sv
  - hdl/cpuController.sv

  # Verification
  - target: test
    files:
      - dv/cpuController_sva.sv
      - dv/cpuControllerTb.sv

// ==== dv/cpuControllerTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuControllerTb;

    import cpuCtrlPkg::*;

    // Stimulus needs about 1030 cycles, the limit leaves close to 2x margin
    localparam int MaxCycles = 2000;

    logic     Clock;
    logic     Reset;
    instrT    Instr;
    psrT      Psr;
    ctrlWordT Ctrl;

    integer      seed;
    logic [31:0] rnd;
    opcodeT      op;
    instrT       ins;
    string       currentTest;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          failedTests = 0;
    int          testStartErrors = 0;

    cpuController dut_i (
        .Clock (Clock),
        .Reset (Reset),
        .Instr (Instr),
        .Psr   (Psr),
        .Ctrl  (Ctrl)
    );

    initial
    begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // Run limit
    always @(posedge Clock)
    begin
        cycleCount++;
        if (cycleCount >= MaxCycles)
        begin
            $display("Timeout: run did not finish within %0d cycles", MaxCycles);
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Datapath fields expected for one instruction word
    function automatic dpCtrlT refDp(instrT word);
        dpCtrlT     d;
        opcodeT     code;
        opcodeT     sub;
        logic [7:0] imm;
        d    = '0;
        code = word[15:12];
        sub  = word[11:8];
        imm  = word[11:4];
        case (code)
            OpAlu, OpCmp:
            begin
                d.opCode   = code;
                d.opExt    = sub;
                d.regA     = word[7:4];
                d.regB     = word[3:0];
                d.aluSrc   = AluSrcReg;
                // Compare only sets flags
                d.regWrite = (code == OpAlu);
                d.regIn    = (code == OpAlu) ? word[3:0] : 4'h0;
            end
            OpAddi, OpSubi, OpCmpi, OpAddui, OpMovi, OpMovui:
            begin
                d.opCode = code;
                d.opExt  = sub;
                d.regB   = word[3:0];
                d.aluSrc = AluSrcImm;
                if (code == OpCmpi)
                begin
                    d.regA = word[7:4];
                end
                else
                begin
                    d.regWrite = 1'b1;
                    d.regIn    = word[3:0];
                end
                if (code == OpMovui)
                    d.immediate = {imm, 8'h00};
                else if (code == OpAddui || code == OpMovi)
                    d.immediate = {8'h00, imm};
                else
                    d.immediate = 16'($signed(imm));
            end
            OpLoadStore:
            begin
                // Address register always in bits 7:4
                if (sub == SubLoad)
                begin
                    d.opExt    = AluMoveExt;
                    d.regWrite = 1'b1;
                    d.regIn    = word[3:0];
                    d.regB     = word[7:4];
                    d.aluSrc   = AluSrcMem;
                end
                else if (sub == SubStore)
                begin
                    d.opExt    = AluMoveExt;
                    d.regA     = word[3:0];
                    d.regB     = word[7:4];
                    d.aluSrc   = AluSrcReg;
                    d.memWrite = 1'b1;
                end
            end
            OpJumpReg:
            begin
                if (sub == SubJumpReg)
                begin
                    d.opExt  = AluMoveExt;
                    d.regA   = word[7:4];
                    d.aluSrc = AluSrcReg;
                end
                else if (sub == SubStorePc)
                begin
                    d.opExt    = AluMoveExt;
                    d.regWrite = 1'b1;
                    d.regIn    = word[3:0];
                    d.aluSrc   = AluSrcPc;
                end
            end
            default:
            begin
            end
        endcase
        return d;
    endfunction

    // PC fields expected for one instruction word and flag set
    function automatic pcCtrlT refPc(instrT word, psrT flags);
        pcCtrlT p;
        logic   holds;
        logic   named;
        named = (word[11:8] <= 4'd4);
        case (word[11:8])
            4'd0:    holds = flags[PsrZero] || flags[PsrGreater];
            4'd1:    holds = flags[PsrHigher] || flags[PsrZero];
            4'd2:    holds = flags[PsrZero];
            4'd3:    holds = !flags[PsrZero] && !flags[PsrGreater];
            4'd4:    holds = !flags[PsrHigher];
            default: holds = 1'b0;
        endcase
        p.pcOffset    = 8'd1;
        p.pcWrite     = 1'b0;
        p.pcIncrement = 1'b1;
        if (word[15:12] == OpSkip && named)
        begin
            p.pcOffset = holds ? 8'd1 : 8'd2;
        end
        else if (word[15:12] == OpJump && (word[11:8] == JumpAlways || (named && holds)))
        begin
            p.pcOffset = word[7:0];
        end
        else if (word[15:12] == OpJumpReg && word[11:8] == SubJumpReg)
        begin
            p.pcOffset    = 8'd0;
            p.pcWrite     = 1'b1;
            p.pcIncrement = 1'b0;
        end
        return p;
    endfunction

    ////////////////////////////////////////////////////////////
    // Helper tasks
    ////////////////////////////////////////////////////////////

    // Errors from testbench checks plus failures of the bound assertions
    function automatic int totalErrors();
        return errorCount + dut_i.cpuControllerSva_i.failCount;
    endfunction

    task automatic beginTest(input string name);
        currentTest     = name;
        testStartErrors = totalErrors();
    endtask

    task automatic endTest();
        int n;
        n = totalErrors() - testStartErrors;
        testCount++;
        if (n != 0)
            failedTests++;
        $display("Test %-12s %s, %0d errors", currentTest, (n == 0) ? "ok" : "FAIL", n);
    endtask

    task automatic compareWord(input string what, input ctrlWordT expected);
        checkCount++;
        assert (Ctrl === expected)
        else
        begin
            errorCount++;
            $display("MISMATCH %s (%s): expected %h actual %h",
                     currentTest, what, expected, Ctrl);
        end
    endtask

    // Called 1 ns into a fetch cycle, returns 1 ns into the next fetch
    task automatic runInstr(input instrT word, input psrT flags);
        ctrlWordT expected;
        Instr              = word;
        Psr                = flags;
        expected           = '0;
        expected.dp        = refDp(word);
        expected.pc        = refPc(word, flags);
        expected.psrEnable = 1'b1;
        @(negedge Clock);
        checkCount++;
        assert (Ctrl.irWrite === 1'b1)
        else
        begin
            errorCount++;
            $display("ERROR %s: controller not in fetch when instruction %h was applied",
                     currentTest, word);
        end
        @(posedge Clock);
        @(negedge Clock);
        compareWord($sformatf("instr %h psr %b", word, flags), expected);
        @(posedge Clock);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        ctrlWordT fetchWord;
        seed  = 32'hf151;
        Reset = 1'b0;
        Instr = '0;
        Psr   = '0;

        // Reset holds output at zero whatever the inputs
        beginTest("reset_fetch");
        repeat (5)
        begin
            @(posedge Clock);
            #1;
            compareWord("in reset", '0);
            rnd   = $random(seed);
            Instr = rnd[15:0];
            Psr   = rnd[20:16];
        end
        Reset = 1'b1;
        fetchWord               = '0;
        fetchWord.memAddrFromPc = 1'b1;
        fetchWord.irWrite       = 1'b1;
        #1;
        compareWord("first fetch", fetchWord);
        @(posedge Clock);
        @(posedge Clock);
        #1;
        endTest();

        // Register ALU, compare, compare immediate
        beginTest("alu_cmp");
        for (int i = 0; i < 48; i++)
        begin
            rnd = $random(seed);
            case (i % 3)
                0:       op = OpAlu;
                1:       op = OpCmp;
                default: op = OpCmpi;
            endcase
            runInstr({op, rnd[11:0]}, rnd[20:16]);
        end
        endTest();

        // Immediate extension, sign bit alternates per opcode
        beginTest("imm_ext");
        for (int i = 0; i < 48; i++)
        begin
            rnd = $random(seed);
            case (i % 6)
                0:       op = OpAddi;
                1:       op = OpSubi;
                2:       op = OpCmpi;
                3:       op = OpAddui;
                4:       op = OpMovi;
                default: op = OpMovui;
            endcase
            ins     = {op, rnd[11:0]};
            ins[11] = ((i / 6) % 2) == 1;
            runInstr(ins, rnd[20:16]);
        end
        endTest();

        // Every flag value for each condition, skip and jump
        beginTest("branch");
        for (int c = 0; c < 5; c++)
        begin
            for (int f = 0; f < 32; f++)
            begin
                rnd = $random(seed);
                runInstr({OpSkip, 4'(c), rnd[7:0]}, 5'(f));
                runInstr({OpJump, 4'(c), rnd[15:8]}, 5'(f));
            end
        end
        for (int i = 0; i < 8; i++)
        begin
            rnd = $random(seed);
            runInstr({OpJump, JumpAlways, rnd[7:0]}, rnd[12:8]);
        end
        endTest();

        // Jump register, store PC, load, store
        beginTest("jump_mem");
        for (int i = 0; i < 32; i++)
        begin
            rnd = $random(seed);
            case (i % 4)
                0:       ins = {OpJumpReg, SubJumpReg, rnd[7:0]};
                1:       ins = {OpJumpReg, SubStorePc, rnd[7:0]};
                2:       ins = {OpLoadStore, SubLoad, rnd[7:0]};
                default: ins = {OpLoadStore, SubStore, rnd[7:0]};
            endcase
            runInstr(ins, rnd[20:16]);
        end
        endTest();

        // Unlisted opcodes and subcodes
        beginTest("noop");
        for (int k = 0; k < 8; k++)
        begin
            rnd = $random(seed);
            case (k / 2)
                0:       op = 4'b0010;
                1:       op = 4'b1101;
                2:       op = 4'b1110;
                default: op = 4'b1111;
            endcase
            runInstr({op, rnd[11:0]}, rnd[20:16]);
        end
        for (int s = 5; s < 16; s++)
        begin
            rnd = $random(seed);
            runInstr({OpSkip, 4'(s), rnd[7:0]}, rnd[12:8]);
            if (s > 5)
                runInstr({OpJump, 4'(s), rnd[15:8]}, rnd[12:8]);
        end
        for (int s = 2; s < 16; s++)
        begin
            rnd = $random(seed);
            runInstr({OpJumpReg, 4'(s), rnd[7:0]}, rnd[12:8]);
            runInstr({OpLoadStore, 4'(s), rnd[15:8]}, rnd[12:8]);
        end
        endTest();

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors, %0d assertion failures",
                 testCount, failedTests, checkCount, errorCount,
                 dut_i.cpuControllerSva_i.failCount);
        if (totalErrors() == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/cpuController_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuControllerSva (
    input wire                       Clock,
    input wire                       Reset,
    input wire cpuCtrlPkg::ctrlWordT Ctrl
);

    import cpuCtrlPkg::*;

    // Number of assertion failures so far
    int failCount = 0;

    ////////////////////////////////////////////////////////////
    // Reset behavior
    ////////////////////////////////////////////////////////////

    // No control activity while held in reset
    property zeroInReset;
        @(posedge Clock) !Reset |-> (Ctrl == '0);
    endproperty

    resetZeroA: assert property (zeroInReset)
    else
    begin
        failCount++;
        $error("control word not zero while reset is low");
    end

    ////////////////////////////////////////////////////////////
    // Phase behavior
    ////////////////////////////////////////////////////////////

    // IR load and flag update belong to different phases
    property exclusivePhase;
        @(posedge Clock) disable iff (!Reset)
            !(Ctrl.irWrite && Ctrl.psrEnable);
    endproperty

    exclusiveA: assert property (exclusivePhase)
    else
    begin
        failCount++;
        $error("irWrite and psrEnable set in the same cycle");
    end

    // Fetch is followed by execute and execute by fetch
    property alternatePhase;
        @(posedge Clock) disable iff (!Reset)
            (Ctrl.irWrite || Ctrl.psrEnable) |=>
                (Ctrl.psrEnable == $past(Ctrl.irWrite)) &&
                (Ctrl.irWrite == $past(Ctrl.psrEnable));
    endproperty

    alternateA: assert property (alternatePhase)
    else
    begin
        failCount++;
        $error("fetch and execute phases did not alternate");
    end

endmodule

// Attach to every controller instance
bind cpuController cpuControllerSva cpuControllerSva_i (
    .Clock (Clock),
    .Reset (Reset),
    .Ctrl  (Ctrl)
);

`default_nettype wire

// ==== files.f ====
hdl/cpuCtrlPkg.sv
hdl/instrDecoder.sv
hdl/branchUnit.sv
hdl/controlSequencer.sv
hdl/cpuController.sv
dv/cpuController_sva.sv
dv/cpuControllerTb.sv

// ==== hdl/branchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  wire cpuCtrlPkg::instrT Instr,
    input  wire cpuCtrlPkg::psrT   Psr,
    output cpuCtrlPkg::pcCtrlT     Pc
);

    import cpuCtrlPkg::*;

    // Fixed PC steps
    localparam pcOffsetT StepOne = 8'd1;
    localparam pcOffsetT StepTwo = 8'd2;

    opcodeT    opcode;
    opcodeT    subCode;
    pcOffsetT  jumpDist;

    assign opcode   = Instr[15:12];
    assign subCode  = Instr[11:8];
    // Relative jump distance
    assign jumpDist = Instr[7:0];

    ////////////////////////////////////////////////////////////
    // Condition evaluation
    ////////////////////////////////////////////////////////////

    logic condHold;
    logic condValid;

    // Only subcodes 0..4 name a condition
    assign condValid = (subCode <= CondLs);

    always_comb
    begin
        case (subCode)
            CondGe:  condHold = Psr[PsrZero] | Psr[PsrGreater];
            CondHs:  condHold = Psr[PsrHigher] | Psr[PsrZero];
            CondEq:  condHold = Psr[PsrZero];
            CondLt:  condHold = ~(Psr[PsrZero] | Psr[PsrGreater]);
            CondLs:  condHold = ~Psr[PsrHigher];
            default: condHold = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // PC control
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Default is a single step
        Pc.pcOffset    = StepOne;
        Pc.pcWrite     = 1'b0;
        Pc.pcIncrement = 1'b1;

        case (opcode)
            // Skip the next word when the condition fails
            OpSkip:
            begin
                if (condValid && !condHold)
                begin
                    Pc.pcOffset = StepTwo;
                end
            end

            OpJump:
            begin
                if (subCode == JumpAlways)
                begin
                    Pc.pcOffset = jumpDist;
                end
                else if (condValid && condHold)
                begin
                    Pc.pcOffset = jumpDist;
                end
            end

            // Load PC from the ALU result instead of stepping
            OpJumpReg:
            begin
                if (subCode == SubJumpReg)
                begin
                    Pc.pcOffset    = '0;
                    Pc.pcWrite     = 1'b1;
                    Pc.pcIncrement = 1'b0;
                end
            end

            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/controlSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
    input  wire                     Clock,
    input  wire                     Reset,
    input  wire cpuCtrlPkg::dpCtrlT Dp,
    input  wire cpuCtrlPkg::pcCtrlT Pc,
    output cpuCtrlPkg::ctrlWordT    Ctrl
);

    import cpuCtrlPkg::*;

    ////////////////////////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////////////////////////

    phaseE phase;

    // Fetch and execute alternate every cycle
    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
        begin
            phase <= PhaseFetch;
        end
        else
        begin
            if (phase == PhaseFetch)
            begin
                phase <= PhaseExecute;
            end
            else
            begin
                phase <= PhaseFetch;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Control word assembly
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Whole word stays zero in reset
        Ctrl = '0;

        if (Reset)
        begin
            if (phase == PhaseFetch)
            begin
                // Memory addressed by PC, result latched into IR
                Ctrl.memAddrFromPc = 1'b1;
                Ctrl.irWrite       = 1'b1;
            end
            else
            begin
                // Decoded instruction drives datapath and PC
                Ctrl.dp        = Dp;
                Ctrl.pc        = Pc;
                Ctrl.psrEnable = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpuController.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuController (
    input  wire                     Clock,
    input  wire                     Reset,
    input  wire cpuCtrlPkg::instrT  Instr,
    input  wire cpuCtrlPkg::psrT    Psr,
    output cpuCtrlPkg::ctrlWordT    Ctrl
);

    import cpuCtrlPkg::*;

    // Decoded fields, valid only in execute
    dpCtrlT dpCtrl;
    pcCtrlT pcCtrl;

    ////////////////////////////////////////////////////////////
    // Datapath and PC decoding
    ////////////////////////////////////////////////////////////

    instrDecoder instrDecoder_i (
        .Instr (Instr),
        .Dp    (dpCtrl)
    );

    // Conditions depend on the status flags
    branchUnit branchUnit_i (
        .Instr (Instr),
        .Psr   (Psr),
        .Pc    (pcCtrl)
    );

    ////////////////////////////////////////////////////////////
    // Phase and output word
    ////////////////////////////////////////////////////////////

    controlSequencer controlSequencer_i (
        .Clock (Clock),
        .Reset (Reset),
        .Dp    (dpCtrl),
        .Pc    (pcCtrl),
        .Ctrl  (Ctrl)
    );

endmodule

`default_nettype wire

// ==== hdl/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////

    // Instruction register contents
    typedef logic [15:0] instrT;
    // Primary opcode, also the ALU extension field
    typedef logic [3:0]  opcodeT;
    // Register file index
    typedef logic [3:0]  regIdxT;
    // Datapath word, immediate operand
    typedef logic [15:0] wordT;
    // PC step or relative jump distance
    typedef logic [7:0]  pcOffsetT;
    // Processor status flags
    typedef logic [4:0]  psrT;

    ////////////////////////////////////////////////////////////
    // Status flag positions
    ////////////////////////////////////////////////////////////

    localparam int PsrGreater = 0;
    localparam int PsrZero    = 1;
    localparam int PsrHigher  = 3;

    ////////////////////////////////////////////////////////////
    // Opcodes, bits 15:12
    ////////////////////////////////////////////////////////////

    localparam opcodeT OpAlu       = 4'b0000;
    localparam opcodeT OpSkip      = 4'b0001;
    localparam opcodeT OpCmp       = 4'b0011;
    localparam opcodeT OpLoadStore = 4'b0100;
    localparam opcodeT OpAddi      = 4'b0101;
    localparam opcodeT OpAddui     = 4'b0110;
    localparam opcodeT OpMovui     = 4'b0111;
    localparam opcodeT OpMovi      = 4'b1000;
    localparam opcodeT OpSubi      = 4'b1001;
    localparam opcodeT OpJump      = 4'b1010;
    localparam opcodeT OpCmpi      = 4'b1011;
    localparam opcodeT OpJumpReg   = 4'b1100;

    // Subcodes in bits 11:8, conditions shared by skip and jump
    localparam opcodeT CondGe      = 4'b0000;
    localparam opcodeT CondHs      = 4'b0001;
    localparam opcodeT CondEq      = 4'b0010;
    localparam opcodeT CondLt      = 4'b0011;
    localparam opcodeT CondLs      = 4'b0100;
    // Unconditional relative jump
    localparam opcodeT JumpAlways  = 4'b0101;
    // Load/store and jump-register group members
    localparam opcodeT SubLoad     = 4'b0000;
    localparam opcodeT SubStore    = 4'b0001;
    localparam opcodeT SubJumpReg  = 4'b0000;
    localparam opcodeT SubStorePc  = 4'b0001;

    // ALU extension that passes operand A
    localparam opcodeT AluMoveExt  = 4'b1101;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    // ALU operand B source
    typedef enum logic [1:0] {
        AluSrcImm = 2'b00,
        AluSrcReg = 2'b01,
        AluSrcMem = 2'b10,
        AluSrcPc  = 2'b11
    } aluSrcE;

    // Sequencer phase
    typedef enum logic {
        PhaseFetch   = 1'b0,
        PhaseExecute = 1'b1
    } phaseE;

    ////////////////////////////////////////////////////////////
    // Control structs
    ////////////////////////////////////////////////////////////

    // Datapath, register file and memory control
    typedef struct packed {
        opcodeT   opCode;
        opcodeT   opExt;
        logic     regWrite;
        regIdxT   regIn;
        regIdxT   regA;
        regIdxT   regB;
        wordT     immediate;
        aluSrcE   aluSrc;
        logic     memWrite;
    } dpCtrlT;

    // Program counter control
    typedef struct packed {
        pcOffsetT pcOffset;
        logic     pcWrite;
        logic     pcIncrement;
    } pcCtrlT;

    // Full controller output
    typedef struct packed {
        dpCtrlT   dp;
        pcCtrlT   pc;
        logic     memAddrFromPc;
        logic     irWrite;
        logic     psrEnable;
    } ctrlWordT;

endpackage

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder (
    input  wire cpuCtrlPkg::instrT Instr,
    output cpuCtrlPkg::dpCtrlT     Dp
);

    import cpuCtrlPkg::*;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    opcodeT      opcode;
    opcodeT      subCode;
    regIdxT      regHi;
    regIdxT      regLo;
    logic [7:0]  immByte;

    assign opcode  = Instr[15:12];
    assign subCode = Instr[11:8];
    // Operand A / address register
    assign regHi   = Instr[7:4];
    // Operand B and destination
    assign regLo   = Instr[3:0];
    // Immediate byte overlaps the subcode field
    assign immByte = Instr[11:4];

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // Anything not matched below stays a no-op
        Dp = '0;

        case (opcode)
            // Register to register ALU
            OpAlu:
            begin
                Dp.opCode   = opcode;
                Dp.opExt    = subCode;
                Dp.regWrite = 1'b1;
                Dp.regIn    = regLo;
                Dp.regA     = regHi;
                Dp.regB     = regLo;
                Dp.aluSrc   = AluSrcReg;
            end

            // Compare, flags only
            OpCmp:
            begin
                Dp.opCode   = opcode;
                Dp.opExt    = subCode;
                Dp.regA     = regHi;
                Dp.regB     = regLo;
                Dp.aluSrc   = AluSrcReg;
            end

            // Signed immediates
            OpAddi, OpSubi:
            begin
                Dp.opCode    = opcode;
                Dp.opExt     = subCode;
                Dp.regWrite  = 1'b1;
                Dp.regIn     = regLo;
                Dp.regB      = regLo;
                Dp.immediate = {{8{immByte[7]}}, immByte};
                Dp.aluSrc    = AluSrcImm;
            end

            // Unsigned add and plain move, zero extended
            OpAddui, OpMovi:
            begin
                Dp.opCode    = opcode;
                Dp.opExt     = subCode;
                Dp.regWrite  = 1'b1;
                Dp.regIn     = regLo;
                Dp.regB      = regLo;
                Dp.immediate = {8'h00, immByte};
                Dp.aluSrc    = AluSrcImm;
            end

            // Move upper, byte goes to bits 15:8
            OpMovui:
            begin
                Dp.opCode    = opcode;
                Dp.opExt     = subCode;
                Dp.regWrite  = 1'b1;
                Dp.regIn     = regLo;
                Dp.regB      = regLo;
                Dp.immediate = {immByte, 8'h00};
                Dp.aluSrc    = AluSrcImm;
            end

            // Compare immediate, no register write
            OpCmpi:
            begin
                Dp.opCode    = opcode;
                Dp.opExt     = subCode;
                Dp.regA      = regHi;
                Dp.regB      = regLo;
                Dp.immediate = {{8{immByte[7]}}, immByte};
                Dp.aluSrc    = AluSrcImm;
            end

            // Memory access through the ALU move path
            OpLoadStore:
            begin
                if (subCode == SubLoad)
                begin
                    Dp.opExt    = AluMoveExt;
                    Dp.regWrite = 1'b1;
                    Dp.regIn    = regLo;
                    Dp.regB     = regHi;
                    Dp.aluSrc   = AluSrcMem;
                end
                else if (subCode == SubStore)
                begin
                    // Data from regLo, address from regHi
                    Dp.opExt    = AluMoveExt;
                    Dp.regA     = regLo;
                    Dp.regB     = regHi;
                    Dp.aluSrc   = AluSrcReg;
                    Dp.memWrite = 1'b1;
                end
            end

            // Register indirect jump and PC save
            OpJumpReg:
            begin
                if (subCode == SubJumpReg)
                begin
                    // Target address moves through operand A
                    Dp.opExt  = AluMoveExt;
                    Dp.regA   = regHi;
                    Dp.aluSrc = AluSrcReg;
                end
                else if (subCode == SubStorePc)
                begin
                    Dp.opExt    = AluMoveExt;
                    Dp.regWrite = 1'b1;
                    Dp.regIn    = regLo;
                    Dp.aluSrc   = AluSrcPc;
                end
            end

            // Skips, relative jumps and unused opcodes
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire
